// ==== drum_consts.svh ====
`ifndef DRUM_CONSTS_SVH
`define DRUM_CONSTS_SVH

// grid shape
`define NUM_COLS 9
`define NUM_ROWS 9
// row index into a column memory
`define ROW_ADDR_W 4
// node word, signed 1.17
`define NODE_W 18

//////////////////////
// 1.17 constants
//////////////////////

// pyramid slope, 2^-9 per unit of edge distance
`define INIT_STEP 18'sh00100
// base wave speed 0.25
`define RHO_0 18'sh08000
// clamp just under 0.5
`define RHO_MAX 18'sh0fc00

// shifts
`define TENSION_SHIFT 4
`define DAMP_SHIFT 10
// node into upper part of a 32 bit audio word
`define SAMPLE_SHIFT 14

// audio core registers
`define FIFO_MIN_SPACE 8'd2
`define AUDIO_FIFO_ADDR 32'h0000_3044
`define AUDIO_LEFT_ADDR 32'h0000_3048
`define AUDIO_RIGHT_ADDR 32'h0000_304c

`endif

// ==== drum_pkg.sv ====
`include "drum_consts.svh"

package drum_pkg;

	// membrane displacement, signed 1.17
	typedef logic signed [`NODE_W-1:0] node_t;

	// row index within a column
	typedef logic [`ROW_ADDR_W-1:0] row_addr_t;

	// one bus master command
	typedef struct packed {
		logic [31:0] address;
		logic [3:0]  byte_enable;
		logic        read;
		logic        write;
		logic [31:0] write_data;
	} bus_req_t;

	// 1.17 times 1.17, keep sign plus 17 fraction bits
	function automatic node_t fx_mul(input node_t a, input node_t b);
		logic signed [2*`NODE_W-1:0] prod;
		prod = a * b;
		return {prod[2*`NODE_W-1], prod[2*`NODE_W-3:`NODE_W-1]};
	endfunction

endpackage

// ==== node_ram.sv ====
`timescale 1ns/1ns
`include "drum_consts.svh"

// one timestep of one column, a row per word
module node_ram (
	input  logic                   CLOCK_50,
	input  logic                   we,
	input  logic [`ROW_ADDR_W-1:0] write_address,
	input  logic [`ROW_ADDR_W-1:0] read_address,
	input  logic [`NODE_W-1:0]     d,
	output logic [`NODE_W-1:0]     q
);

	logic [`NODE_W-1:0] mem [`NUM_ROWS];

	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			mem[write_address] <= d;
		end
		// old data on a same-address read, one cycle latency
		q <= mem[read_address];
	end

endmodule

// ==== node_update.sv ====
`timescale 1ns/1ns
`include "drum_consts.svh"

// finite-difference step for a single node
module node_update import drum_pkg::*; (
	input  node_t rho,
	input  node_t u_top,
	input  node_t u_bottom,
	input  node_t u_left,
	input  node_t u_right,
	input  node_t u_prev,
	input  node_t u_curr,
	output node_t u_next
);

	node_t dif_sum;
	node_t rho_term;
	node_t mid;

	// discrete laplacian over the four neighbors
	assign dif_sum = (u_left - u_curr) + (u_right - u_curr)
		+ (u_bottom - u_curr) + (u_top - u_curr);

	// scaled by the wave speed
	assign rho_term = fx_mul(rho, dif_sum);

	// leapfrog in time, previous step slightly damped
	assign mid = rho_term + (u_curr <<< 1) - u_prev + (u_prev >>> `DAMP_SHIFT);

	// output damping
	assign u_next = mid - (mid >>> `DAMP_SHIFT);

endmodule

// ==== drum_column.sv ====
`timescale 1ns/1ns
`include "drum_consts.svh"

// one solver column, sweeps bottom row to top row each timestep
module drum_column import drum_pkg::*; #(
	parameter int col = 0
) (
	input  logic  CLOCK_50,
	input  logic  rst,
	input  node_t rho,
	input  node_t u_left,
	input  node_t u_right,
	input  logic  step_req,
	output node_t u_curr,
	output node_t center_val
);

	// distance of this column to the side edges
	localparam int COL_DIST = (col < `NUM_COLS - 1 - col) ? col : `NUM_COLS - 1 - col;
	localparam row_addr_t TOP_ROW = row_addr_t'(`NUM_ROWS - 1);
	localparam row_addr_t MID_ROW = row_addr_t'(`NUM_ROWS / 2);

	typedef enum logic [2:0] {
		FILL,
		SETTLE_A,
		SETTLE_B,
		READ_WAIT,
		CALC,
		ADVANCE
	} state_t;

	state_t    state;
	row_addr_t row;
	row_addr_t curr_rd_addr;
	row_addr_t row_dist;
	row_addr_t edge_dist;
	logic      at_top;
	logic      ram_we;
	node_t     q_curr;
	node_t     q_prev;
	node_t     top_val;
	node_t     bottom;
	node_t     u_next;
	node_t     init_val;
	node_t     curr_wd;
	node_t     prev_wd;

	assign at_top = (row == TOP_ROW);

	//////////////////////
	// initial pyramid
	//////////////////////

	assign row_dist = (row < TOP_ROW - row) ? row : TOP_ROW - row;
	assign edge_dist = (row_dist < COL_DIST) ? row_dist : row_addr_t'(COL_DIST);
	assign init_val = node_t'(edge_dist) * `INIT_STEP;

	//////////////////////
	// node memories
	//////////////////////

	// top neighbor is one row up; at the top row fetch row 0 for the next sweep
	assign curr_rd_addr = at_top ? '0 : row_addr_t'(row + 1'b1);
	assign ram_we = (state == FILL) || (state == CALC);
	assign curr_wd = (state == FILL) ? init_val : u_next;
	assign prev_wd = (state == FILL) ? init_val : u_curr;

	node_ram u_curr_ram (
		.CLOCK_50      (CLOCK_50),
		.we            (ram_we),
		.write_address (row),
		.read_address  (curr_rd_addr),
		.d             (curr_wd),
		.q             (q_curr)
	);

	node_ram u_prev_ram (
		.CLOCK_50      (CLOCK_50),
		.we            (ram_we),
		.write_address (row),
		.read_address  (row),
		.d             (prev_wd),
		.q             (q_prev)
	);

	// zero boundary above the top row
	assign top_val = at_top ? '0 : q_curr;

	node_update u_node_update (
		.rho      (rho),
		.u_top    (top_val),
		.u_bottom (bottom),
		.u_left   (u_left),
		.u_right  (u_right),
		.u_prev   (q_prev),
		.u_curr   (u_curr),
		.u_next   (u_next)
	);

	//////////////////////
	// sweep control
	//////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= FILL;
			row <= '0;
			center_val <= '0;
		end else begin
			case (state)
				// one row per cycle, row stays at the top afterwards
				FILL: begin
					if (at_top) begin
						state <= SETTLE_A;
					end else begin
						row <= row + 1'b1;
					end
				end
				// row 0 read in flight
				SETTLE_A: begin
					state <= SETTLE_B;
				end
				SETTLE_B: begin
					u_curr <= q_curr;
					bottom <= '0;
					row <= '0;
					state <= READ_WAIT;
				end
				READ_WAIT: begin
					state <= CALC;
				end
				// write new and old value, shift the window up a row
				CALC: begin
					bottom <= u_curr;
					u_curr <= q_curr;
					if (row == MID_ROW) begin
						center_val <= u_curr;
					end
					state <= ADVANCE;
				end
				ADVANCE: begin
					if (!at_top) begin
						row <= row + 1'b1;
						state <= READ_WAIT;
					end else if (step_req) begin
						// next timestep, bottom boundary back to zero
						row <= '0;
						bottom <= '0;
						state <= READ_WAIT;
					end
				end
				default: begin
					state <= FILL;
				end
			endcase
		end
	end

endmodule

// ==== drum_grid.sv ====
`timescale 1ns/1ns
`include "drum_consts.svh"

// all solver columns plus the shared nonlinear wave speed
module drum_grid import drum_pkg::*; (
	input  logic  CLOCK_50,
	input  logic  rst,
	input  logic  step_req,
	output node_t center
);

	node_t col_val [`NUM_COLS];
	node_t col_center [`NUM_COLS];
	node_t rho_eff;
	node_t tension_in;
	node_t rho_tension;
	node_t rho_sum;

	//////////////////////
	// columns
	//////////////////////

	for (genvar i = 0; i < `NUM_COLS; i++) begin : g_col
		// guarded indices, values outside the grid are zero
		localparam int LEFT = (i > 0) ? i - 1 : 0;
		localparam int RIGHT = (i < `NUM_COLS - 1) ? i + 1 : `NUM_COLS - 1;

		drum_column #(
			.col (i)
		) u_drum_column (
			.CLOCK_50   (CLOCK_50),
			.rst        (rst),
			.rho        (rho_eff),
			.u_left     ((i > 0) ? col_val[LEFT] : node_t'(0)),
			.u_right    ((i < `NUM_COLS - 1) ? col_val[RIGHT] : node_t'(0)),
			.step_req   (step_req),
			.u_curr     (col_val[i]),
			.center_val (col_center[i])
		);
	end

	// middle column holds the center node
	assign center = col_center[`NUM_COLS / 2];

	//////////////////////
	// nonlinear rho
	//////////////////////

	// stiffer membrane with larger center displacement
	assign tension_in = center >>> `TENSION_SHIFT;
	assign rho_tension = fx_mul(tension_in, tension_in);
	assign rho_sum = `RHO_0 + rho_tension;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			rho_eff <= `RHO_0;
		end else if (rho_sum > `RHO_MAX) begin
			rho_eff <= `RHO_MAX;
		end else begin
			rho_eff <= rho_sum;
		end
	end

endmodule

// ==== audio_bus_master.sv ====
`timescale 1ns/1ns
`include "drum_consts.svh"

// feeds the audio FIFO with the center sample, one frame per timestep
module audio_bus_master import drum_pkg::*; (
	input  logic        CLOCK_50,
	input  logic        rst,
	input  node_t       center,
	output bus_req_t    bus,
	input  logic        bus_ack,
	input  logic [31:0] bus_read_data,
	output logic        step_req
);

	typedef enum logic [2:0] {
		S_READ,
		S_READ_ACK,
		S_CHECK,
		S_LEFT_ACK,
		S_RIGHT,
		S_RIGHT_ACK
	} state_t;

	state_t     state;
	logic [7:0] fifo_space;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= S_READ;
			bus <= '0;
			step_req <= 1'b0;
		end else begin
			case (state)
				// ask for the free FIFO space
				S_READ: begin
					bus.address <= `AUDIO_FIFO_ADDR;
					bus.byte_enable <= 4'hf;
					bus.read <= 1'b1;
					state <= S_READ_ACK;
				end
				// space sits in the top byte
				S_READ_ACK: begin
					if (bus_ack) begin
						fifo_space <= bus_read_data[31:24];
						bus.read <= 1'b0;
						state <= S_CHECK;
					end
				end
				S_CHECK: begin
					if (fifo_space > `FIFO_MIN_SPACE) begin
						// left channel, sign extended center
						bus.address <= `AUDIO_LEFT_ADDR;
						bus.byte_enable <= 4'hf;
						bus.write_data <= 32'(center) << `SAMPLE_SHIFT;
						bus.write <= 1'b1;
						state <= S_LEFT_ACK;
					end else begin
						// too full, poll again
						state <= S_READ;
					end
				end
				S_LEFT_ACK: begin
					if (bus_ack) begin
						bus.write <= 1'b0;
						state <= S_RIGHT;
					end
				end
				// same word to the right channel
				// release the columns for their next timestep
				S_RIGHT: begin
					bus.address <= `AUDIO_RIGHT_ADDR;
					bus.write <= 1'b1;
					step_req <= 1'b1;
					state <= S_RIGHT_ACK;
				end
				S_RIGHT_ACK: begin
					step_req <= 1'b0;
					if (bus_ack) begin
						bus.write <= 1'b0;
						state <= S_READ;
					end
				end
				default: begin
					state <= S_READ;
				end
			endcase
		end
	end

endmodule

// ==== drum_synth_top.sv ====
`timescale 1ns/1ns
`include "drum_consts.svh"

// membrane solver grid feeding the audio bus master
module drum_synth_top import drum_pkg::*; (
	input  logic        CLOCK_50,
	input  logic        rst,
	output bus_req_t    bus,
	input  logic        bus_ack,
	input  logic [31:0] bus_read_data
);

	// center node sample
	node_t center;
	// start of the next timestep
	logic  step_req;

	drum_grid u_drum_grid (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.step_req (step_req),
		.center   (center)
	);

	audio_bus_master u_audio_bus_master (
		.CLOCK_50      (CLOCK_50),
		.rst           (rst),
		.center        (center),
		.bus           (bus),
		.bus_ack       (bus_ack),
		.bus_read_data (bus_read_data),
		.step_req      (step_req)
	);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

// free running clock plus a reset held for a few cycles
module tb_clock #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic CLOCK_50,
	output logic rst
);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	// release on a rising edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		rst <= 1'b0;
	end

endmodule

// ==== tb_drum_synth.sv ====
`timescale 1ns/1ns
`include "drum_consts.svh"

module tb_drum_synth import drum_pkg::*; ();

	localparam int CLOCK_PERIOD = 40;
	// generous worst case per frame with polls included
	localparam int FRAME_CYCLES = 32;
	localparam int WATCHDOG_FRAMES = 400;
	localparam int TARGET_FRAMES = 24;
	localparam logic [31:0] SEED = 32'hcc33068e;

	logic        CLOCK_50;
	logic        rst;
	bus_req_t    bus;
	logic        bus_ack;
	logic [31:0] bus_read_data;

	logic [31:0] lfsr_state = SEED;
	logic [31:0] slave_rnd;
	logic        slave_busy;
	int          ack_wait;

	// bus history seen by the checks
	logic        seen_cmd;
	logic        pending_poll;
	logic        pending_left;
	logic        pending_right;
	logic [31:0] left_data;
	logic        nonzero_seen;
	logic        changed_seen;
	logic [31:0] first_sample;
	logic        left_done;
	logic        right_done;
	int          write_frames;
	int          hit_count [1:6];
	int          fail_count [1:6];
	int          total_fail;
	string       test_name [1:6] = '{"reset and first read", "strobe handshake",
		"poll on low space", "left then right write", "first sample", "relaxing peak"};

	tb_clock #(
		.PERIOD       (CLOCK_PERIOD),
		.RESET_CYCLES (3)
	) u_tb_clock (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst)
	);

	drum_synth_top u_drum_synth_top (
		.CLOCK_50      (CLOCK_50),
		.rst           (rst),
		.bus           (bus),
		.bus_ack       (bus_ack),
		.bus_read_data (bus_read_data)
	);

	////////////////////
	// helpers
	////////////////////

	// galois form shifting right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// nearest grid edge counted from zero
	function automatic int edge_distance(input int r, input int c);
		int d;
		d = r;
		if (`NUM_ROWS - 1 - r < d) d = `NUM_ROWS - 1 - r;
		if (c < d) d = c;
		if (`NUM_COLS - 1 - c < d) d = `NUM_COLS - 1 - c;
		return d;
	endfunction

	// initial pyramid height as an audio word
	function automatic logic [31:0] pyramid_sample(input int r, input int c);
		logic signed [31:0] node;
		node = 32'(`INIT_STEP) * edge_distance(r, c);
		return node << `SAMPLE_SHIFT;
	endfunction

	function automatic logic all_tests_reached();
		for (int k = 1; k <= 6; k++) begin
			if (hit_count[k] == 0) return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic show_mismatch(input int test, input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
		fail_count[test]++;
	endtask

	task automatic record_failure(input int test, input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		fail_count[test]++;
	endtask

	////////////////////
	// audio core model
	////////////////////

	// ack after 1 to 4 cycles with space 0 to 8 in the top byte
	always @(posedge CLOCK_50) begin
		if (rst) begin
			bus_ack <= 1'b0;
			slave_busy <= 1'b0;
		end else if (bus_ack) begin
			bus_ack <= 1'b0;
			slave_busy <= 1'b0;
		end else if (slave_busy) begin
			if (ack_wait <= 1) begin
				bus_ack <= 1'b1;
				if (bus.read) begin
					draw_bits(4, slave_rnd);
					bus_read_data <= {8'(slave_rnd % 32'd9), 24'h0};
				end
			end else begin
				ack_wait <= ack_wait - 1;
			end
		end else if (bus.read || bus.write) begin
			draw_bits(2, slave_rnd);
			ack_wait <= int'(slave_rnd) + 1;
			slave_busy <= 1'b1;
		end
	end

	assign left_done = bus.write && bus_ack && bus.address == `AUDIO_LEFT_ADDR;
	assign right_done = bus.write && bus_ack && bus.address == `AUDIO_RIGHT_ADDR;

	// expected next command and reach counts
	always @(posedge CLOCK_50) begin
		if (rst) begin
			seen_cmd <= 1'b0;
			pending_poll <= 1'b0;
			pending_left <= 1'b0;
			pending_right <= 1'b0;
			nonzero_seen <= 1'b0;
			changed_seen <= 1'b0;
		end else begin
			if (bus.read || bus.write) begin
				if (!seen_cmd) hit_count[1]++;
				seen_cmd <= 1'b1;
				pending_poll <= 1'b0;
				pending_left <= 1'b0;
				pending_right <= 1'b0;
			end
			if ((bus.read || bus.write) && bus_ack) hit_count[2]++;
			if (bus.read && bus_ack) begin
				if (bus_read_data[31:24] > `FIFO_MIN_SPACE) begin
					pending_left <= 1'b1;
					hit_count[4]++;
				end else begin
					pending_poll <= 1'b1;
					hit_count[3]++;
				end
			end
			if (left_done) begin
				pending_right <= 1'b1;
				left_data <= bus.write_data;
				if (!nonzero_seen) begin
					if (bus.write_data != 0) begin
						nonzero_seen <= 1'b1;
						first_sample <= bus.write_data;
						hit_count[5]++;
					end
				end else if (!changed_seen && bus.write_data != first_sample) begin
					changed_seen <= 1'b1;
					hit_count[6]++;
				end
			end
			if (right_done) write_frames++;
		end
	end

	////////////////////
	// checks
	////////////////////

	// quiet bus out of reset then a full-word space read first
	a_reset_quiet: assert property (@(posedge CLOCK_50) rst |=> !bus.read && !bus.write)
		else show_mismatch(1, "bus.read/bus.write", 32'd0, 32'($sampled({bus.read, bus.write})));
	a_first_read: assert property (@(posedge CLOCK_50) disable iff (rst)
		(bus.read || bus.write) && !seen_cmd |-> bus.read && !bus.write)
		else show_mismatch(1, "bus.read", 32'd1, 32'($sampled(bus.read)));
	a_first_addr: assert property (@(posedge CLOCK_50) disable iff (rst)
		(bus.read || bus.write) && !seen_cmd |-> bus.address == `AUDIO_FIFO_ADDR)
		else show_mismatch(1, "bus.address", `AUDIO_FIFO_ADDR, $sampled(bus.address));
	a_first_be: assert property (@(posedge CLOCK_50) disable iff (rst)
		(bus.read || bus.write) && !seen_cmd |-> bus.byte_enable == 4'hf)
		else show_mismatch(1, "bus.byte_enable", 32'hf, 32'($sampled(bus.byte_enable)));

	// handshake
	a_one_strobe: assert property (@(posedge CLOCK_50) disable iff (rst)
		!(bus.read && bus.write))
		else record_failure(2, "read and write strobes are high in the same cycle");
	a_read_hold: assert property (@(posedge CLOCK_50) disable iff (rst)
		bus.read && !bus_ack |=> bus.read)
		else show_mismatch(2, "bus.read", 32'd1, 32'($sampled(bus.read)));
	a_write_hold: assert property (@(posedge CLOCK_50) disable iff (rst)
		bus.write && !bus_ack |=> bus.write)
		else show_mismatch(2, "bus.write", 32'd1, 32'($sampled(bus.write)));
	a_read_drop: assert property (@(posedge CLOCK_50) disable iff (rst)
		bus.read && bus_ack |=> !bus.read)
		else show_mismatch(2, "bus.read", 32'd0, 32'($sampled(bus.read)));
	a_write_drop: assert property (@(posedge CLOCK_50) disable iff (rst)
		bus.write && bus_ack |=> !bus.write)
		else show_mismatch(2, "bus.write", 32'd0, 32'($sampled(bus.write)));

	// low space means poll again
	a_poll_again: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_poll && (bus.read || bus.write) |-> !bus.write)
		else show_mismatch(3, "bus.write", 32'd0, 32'($sampled(bus.write)));
	a_poll_addr: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_poll && (bus.read || bus.write) |-> bus.address == `AUDIO_FIFO_ADDR)
		else show_mismatch(3, "bus.address", `AUDIO_FIFO_ADDR, $sampled(bus.address));

	// room in the FIFO means left then right
	a_left_cmd: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_left && (bus.read || bus.write) |-> bus.write)
		else show_mismatch(4, "bus.write", 32'd1, 32'($sampled(bus.write)));
	a_left_addr: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_left && (bus.read || bus.write) |-> bus.address == `AUDIO_LEFT_ADDR)
		else show_mismatch(4, "bus.address", `AUDIO_LEFT_ADDR, $sampled(bus.address));
	a_left_be: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_left && (bus.read || bus.write) |-> bus.byte_enable == 4'hf)
		else show_mismatch(4, "bus.byte_enable", 32'hf, 32'($sampled(bus.byte_enable)));
	a_left_low: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_left && bus.write |-> bus.write_data[`SAMPLE_SHIFT-1:0] == '0)
		else show_mismatch(4, "bus.write_data low bits", 32'd0,
			32'($sampled(bus.write_data[`SAMPLE_SHIFT-1:0])));
	a_right_addr: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_right && (bus.read || bus.write) |-> bus.write
		&& bus.address == `AUDIO_RIGHT_ADDR)
		else show_mismatch(4, "bus.address", `AUDIO_RIGHT_ADDR, $sampled(bus.address));
	a_right_be: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_right && bus.write |-> bus.byte_enable == 4'hf)
		else show_mismatch(4, "bus.byte_enable", 32'hf, 32'($sampled(bus.byte_enable)));
	a_right_data: assert property (@(posedge CLOCK_50) disable iff (rst)
		pending_right && bus.write |-> bus.write_data == left_data)
		else show_mismatch(4, "bus.write_data", $sampled(left_data), $sampled(bus.write_data));

	// center of the pyramid comes out first
	a_first_sample: assert property (@(posedge CLOCK_50) disable iff (rst)
		left_done && !nonzero_seen && bus.write_data != 0
		|-> bus.write_data == pyramid_sample(`NUM_ROWS / 2, `NUM_COLS / 2))
		else show_mismatch(5, "bus.write_data", pyramid_sample(`NUM_ROWS / 2, `NUM_COLS / 2),
			$sampled(bus.write_data));

	// peak relaxes toward its lower neighbors
	a_relax: assert property (@(posedge CLOCK_50) disable iff (rst)
		left_done && nonzero_seen && !changed_seen && bus.write_data != first_sample
		|-> $signed(bus.write_data) < $signed(first_sample))
		else begin
			$display("FAIL %0t bus.write_data expected below %h got %h", $time,
				$sampled(first_sample), $sampled(bus.write_data));
			fail_count[6]++;
		end

	////////////////////
	// run control
	////////////////////

	initial begin
		bus_ack = 1'b0;
		bus_read_data = '0;
		write_frames = 0;
		for (int k = 1; k <= 6; k++) begin
			hit_count[k] = 0;
			fail_count[k] = 0;
		end
		@(negedge rst);
		// counters settle between rising edges
		do begin
			@(negedge CLOCK_50);
		end while (!(all_tests_reached() && write_frames >= TARGET_FRAMES));
		total_fail = 0;
		for (int k = 1; k <= 6; k++) begin
			$display("test %0d %s: reached %0d times, %0d errors", k, test_name[k],
				hit_count[k], fail_count[k]);
			total_fail += fail_count[k];
		end
		$display("6 tests, %0d frames written, %0d errors", write_frames, total_fail);
		if (total_fail == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// upper bound on the whole run
	initial begin
		#(WATCHDOG_FRAMES * FRAME_CYCLES * CLOCK_PERIOD);
		$display("watchdog expired after %0d frames of cycles, not every test was reached",
			WATCHDOG_FRAMES);
		$display("test failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
drum_pkg.sv
node_ram.sv
node_update.sv
drum_column.sv
drum_grid.sv
audio_bus_master.sv
drum_synth_top.sv
tb_clock.sv
tb_drum_synth.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_drum_synth
FILELIST  = list.f
SIM       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status follows the pass message in the output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
